// File: logic/capture_pkg.sv
package capture_pkg;

    localparam int sample_w   = 18;  // front end sample width
    localparam int word_w     = 64;  // fifo and memory word
    localparam int axi_addr_w = 4;
    localparam int axi_data_w = 32;

    typedef enum logic {
        mode_sample = 1'b0,  // full 18-bit samples
        mode_byte   = 1'b1   // low byte of each sample only
    } pack_mode_e;

    // register map, byte offsets
    localparam logic [axi_addr_w-1:0] reg_ctrl   = 4'h0;  // bit0 enable, bit1 mode
    localparam logic [axi_addr_w-1:0] reg_cmd    = 4'h4;  // start, stop, clear errors
    localparam logic [axi_addr_w-1:0] reg_status = 4'h8;  // overflow, underflow, capturing

endpackage

// File: logic/pulse_sync.sv
`timescale 1ns/1ps

module pulse_sync #(
    parameter int sync_stages = 2
) (
    input  logic  src_clk,
    input  logic  dst_clk,
    input  logic  reset,
    input  logic  src_pulse,
    output logic  dst_pulse
);

    logic                    src_toggle;
    logic [sync_stages-1:0]  sync_q;
    logic                    last_q;  // previous synced level

    always_ff @(posedge src_clk) begin
        if (reset)
            src_toggle <= 1'b0;
        else if (src_pulse)
            src_toggle <= ~src_toggle;  // one flip per pulse
    end

    always_ff @(posedge dst_clk) begin
        if (reset) begin
            sync_q <= '0;
            last_q <= 1'b0;
        end else begin
            sync_q <= {sync_q[sync_stages-2:0], src_toggle};
            last_q <= sync_q[sync_stages-1];
        end
    end

    assign dst_pulse = sync_q[sync_stages-1] ^ last_q;

endmodule

// File: logic/dual_clock_fifo.sv
`timescale 1ns/1ps

module dual_clock_fifo #(
    parameter int fifo_depth_log2 = 9,
    parameter int sync_stages     = 2
) (
    input  logic                            wr_clk,
    input  logic                            rd_clk,
    input  logic                            reset,
    input  logic                            wr_en,
    input  logic [capture_pkg::word_w-1:0]  wr_data,
    output logic                            full,
    output logic                            overflow,
    input  logic                            rd_en,
    output logic [capture_pkg::word_w-1:0]  rd_data,
    output logic                            empty,
    output logic                            underflow
);

    localparam int depth = 1 << fifo_depth_log2;
    localparam int aw    = fifo_depth_log2;

    logic [capture_pkg::word_w-1:0] mem [depth];
    logic [aw:0]  wbin;
    logic [aw:0]  wgray;
    logic [aw:0]  wbin_next;
    logic [aw:0]  rbin;
    logic [aw:0]  rgray;
    logic [aw:0]  rbin_next;
    logic [aw:0]  rgray_wq [sync_stages];  // read pointer, write side view
    logic [aw:0]  wgray_rq [sync_stages];  // write pointer, read side view
    logic [aw:0]  rgray_w;
    logic [aw:0]  wgray_r;
    logic         wr_ok;
    logic         rd_ok;

    assign rgray_w   = rgray_wq[sync_stages-1];
    assign wgray_r   = wgray_rq[sync_stages-1];
    assign wbin_next = wbin + 1'b1;
    assign rbin_next = rbin + 1'b1;

    // full when the two top gray bits differ and the rest match
    assign full  = (wgray == {~rgray_w[aw:aw-1], rgray_w[aw-2:0]});
    assign empty = (rgray == wgray_r);
    assign wr_ok = wr_en & ~full;
    assign rd_ok = rd_en & ~empty;

    always_ff @(posedge wr_clk) begin
        if (reset) begin
            wbin     <= '0;
            wgray    <= '0;
            overflow <= 1'b0;
            rgray_wq <= '{default: '0};
        end else begin
            overflow <= wr_en & full;  // write dropped
            if (wr_ok) begin
                wbin  <= wbin_next;
                wgray <= wbin_next ^ (wbin_next >> 1);
            end
            rgray_wq[0] <= rgray;
            for (int i = 1; i < sync_stages; i++)
                rgray_wq[i] <= rgray_wq[i-1];
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_ok)
            mem[wbin[aw-1:0]] <= wr_data;
    end

    always_ff @(posedge rd_clk) begin
        if (reset) begin
            rbin      <= '0;
            rgray     <= '0;
            underflow <= 1'b0;
            wgray_rq  <= '{default: '0};
        end else begin
            underflow <= rd_en & empty;
            if (rd_ok) begin
                rbin  <= rbin_next;
                rgray <= rbin_next ^ (rbin_next >> 1);
            end
            wgray_rq[0] <= wgray;
            for (int i = 1; i < sync_stages; i++)
                wgray_rq[i] <= wgray_rq[i-1];
        end
    end

    // registered output, keeps old word on an empty read
    always_ff @(posedge rd_clk) begin
        if (rd_ok)
            rd_data <= mem[rbin[aw-1:0]];
    end

endmodule

// File: logic/sample_packer.sv
`timescale 1ns/1ps

module sample_packer (
    input  logic                               wr_clk,
    input  logic                               reset,
    input  logic                               enable,
    input  capture_pkg::pack_mode_e            mode,
    input  logic                               capture_start,
    input  logic                               capture_stop,
    input  logic                               clear_errors,
    input  logic [capture_pkg::sample_w-1:0]   sample_data,
    input  logic                               sample_valid,
    input  logic                               full,
    input  logic                               overflow,
    output logic                               wr_en,
    output logic [capture_pkg::word_w-1:0]     wr_data,
    output logic                               overflow_sticky,
    output logic                               capturing,
    output logic                               flush_done,
    output logic                               start_seen
);

    localparam int acc_w  = 2 * capture_pkg::word_w;
    localparam int fill_w = $clog2(acc_w) + 1;

    logic [acc_w-1:0]   acc;          // pending bits, msb aligned, zeros below
    logic [fill_w-1:0]  fill;
    logic [acc_w-1:0]   ins;
    logic [acc_w-1:0]   acc_app;      // accumulator with this sample appended
    logic [fill_w-1:0]  fill_app;
    logic               take;
    logic               flush_pend;   // stop taken, padded word due
    logic               flush_wrote;

    assign take = capturing & enable & sample_valid;

    always_comb begin
        if (mode == capture_pkg::mode_byte) begin
            ins      = {sample_data[7:0], {(acc_w-8){1'b0}}};
            fill_app = fill + fill_w'(8);
        end else begin
            ins      = {sample_data, {(acc_w-capture_pkg::sample_w){1'b0}}};
            fill_app = fill + fill_w'(capture_pkg::sample_w);
        end
        acc_app = acc | (ins >> fill);  // lands right below pending bits
    end

    always_ff @(posedge wr_clk) begin
        if (reset) begin
            acc         <= '0;
            fill        <= '0;
            wr_en       <= 1'b0;
            capturing   <= 1'b0;
            flush_pend  <= 1'b0;
            flush_wrote <= 1'b0;
            flush_done  <= 1'b0;
            start_seen  <= 1'b0;
        end else begin
            wr_en       <= 1'b0;
            flush_pend  <= 1'b0;
            flush_wrote <= 1'b0;
            flush_done  <= flush_wrote;  // one cycle behind the padded write
            start_seen  <= capture_start & enable;
            if (capture_start && enable) begin
                capturing <= 1'b1;
                acc       <= '0;
                fill      <= '0;
            end else if (capture_stop && capturing) begin
                capturing  <= 1'b0;
                flush_pend <= 1'b1;
            end else if (flush_pend) begin
                wr_en       <= (fill != '0);  // nothing pending, no write
                flush_wrote <= 1'b1;
                acc         <= '0;
                fill        <= '0;
            end else if (take) begin
                if (fill_app >= fill_w'(capture_pkg::word_w)) begin
                    wr_en <= 1'b1;
                    acc   <= acc_app << capture_pkg::word_w;
                    fill  <= fill_app - fill_w'(capture_pkg::word_w);
                end else begin
                    acc  <= acc_app;
                    fill <= fill_app;
                end
            end
        end
    end

    // top word, low bits already zero when flushing
    always_ff @(posedge wr_clk) begin
        if (flush_pend)
            wr_data <= acc[acc_w-1 -: capture_pkg::word_w];
        else
            wr_data <= acc_app[acc_w-1 -: capture_pkg::word_w];
    end

    always_ff @(posedge wr_clk) begin
        if (reset)
            overflow_sticky <= 1'b0;
        else if (capture_start || clear_errors)
            overflow_sticky <= 1'b0;
        else if (overflow || (wr_en && full))
            overflow_sticky <= 1'b1;  // set on the dropped write itself
    end

endmodule

// File: logic/capture_regs.sv
`timescale 1ns/1ps

module capture_regs #(
    parameter int sync_stages = 2
) (
    input  logic                                  wr_clk,
    input  logic                                  reset,
    input  logic [capture_pkg::axi_addr_w-1:0]    awaddr,
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [capture_pkg::axi_data_w-1:0]    wdata,
    input  logic [capture_pkg::axi_data_w/8-1:0]  wstrb,
    input  logic                                  wvalid,
    output logic                                  wready,
    output logic [1:0]                            bresp,
    output logic                                  bvalid,
    input  logic                                  bready,
    input  logic [capture_pkg::axi_addr_w-1:0]    araddr,
    input  logic                                  arvalid,
    output logic                                  arready,
    output logic [capture_pkg::axi_data_w-1:0]    rdata,
    output logic [1:0]                            rresp,
    output logic                                  rvalid,
    input  logic                                  rready,
    input  logic                                  overflow_sticky,
    input  logic                                  underflow_sticky,  // rd_clk domain
    input  logic                                  capturing,
    output logic                                  enable,
    output capture_pkg::pack_mode_e               mode,
    output logic                                  capture_start,
    output logic                                  capture_stop,
    output logic                                  clear_errors
);

    logic                                wr_fire;
    logic                                rd_fire;
    logic [sync_stages-1:0]              uf_sync;  // underflow flag into wr_clk
    logic [capture_pkg::axi_data_w-1:0]  ctrl_word;
    logic [capture_pkg::axi_data_w-1:0]  status_word;

    assign wr_fire = awready & awvalid & wvalid;
    assign rd_fire = arready & arvalid;
    assign bresp   = 2'b00;  // always OKAY
    assign rresp   = 2'b00;

    assign ctrl_word   = {{(capture_pkg::axi_data_w-2){1'b0}}, mode, enable};
    assign status_word = {{(capture_pkg::axi_data_w-3){1'b0}}, capturing,
                          uf_sync[sync_stages-1], overflow_sticky};

    // write channel: address and data taken together
    always_ff @(posedge wr_clk) begin
        if (reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            awready <= awvalid & wvalid & ~awready & ~bvalid;
            wready  <= awvalid & wvalid & ~awready & ~bvalid;
            if (wr_fire)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;  // held until taken
        end
    end

    always_ff @(posedge wr_clk) begin
        if (reset) begin
            enable        <= 1'b0;
            mode          <= capture_pkg::mode_sample;
            capture_start <= 1'b0;
            capture_stop  <= 1'b0;
            clear_errors  <= 1'b0;
        end else begin
            capture_start <= 1'b0;  // commands are single pulses
            capture_stop  <= 1'b0;
            clear_errors  <= 1'b0;
            if (wr_fire && wstrb[0]) begin
                if (awaddr == capture_pkg::reg_ctrl) begin
                    enable <= wdata[0];
                    mode   <= capture_pkg::pack_mode_e'(wdata[1]);
                end
                if (awaddr == capture_pkg::reg_cmd) begin
                    capture_start <= wdata[0];
                    capture_stop  <= wdata[1];
                    clear_errors  <= wdata[2];
                end
            end
        end
    end

    // read channel
    always_ff @(posedge wr_clk) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            uf_sync <= '0;
        end else begin
            arready <= arvalid & ~arready & ~rvalid;
            uf_sync <= {uf_sync[sync_stages-2:0], underflow_sticky};
            if (rd_fire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (rd_fire) begin
            case (araddr)
                capture_pkg::reg_ctrl:   rdata <= ctrl_word;
                capture_pkg::reg_status: rdata <= status_word;
                default:                 rdata <= '0;  // cmd and holes read zero
            endcase
        end
    end

endmodule

// File: logic/drain_monitor.sv
`timescale 1ns/1ps

module drain_monitor (
    input  logic  rd_clk,
    input  logic  reset,
    input  logic  enable_rd,     // wr_clk level, synchronized here
    input  logic  flush_done,
    input  logic  start_seen,
    input  logic  clear_errors,
    input  logic  empty,
    input  logic  underflow,
    output logic  capture_done_out,
    output logic  underflow_sticky
);

    logic [1:0]  enable_q;
    logic        empty_q;
    logic        done_pend;  // flush arrived, waiting for drain

    always_ff @(posedge rd_clk) begin
        if (reset) begin
            enable_q         <= 2'b00;
            empty_q          <= 1'b0;
            done_pend        <= 1'b0;
            capture_done_out <= 1'b0;
        end else begin
            enable_q         <= {enable_q[0], enable_rd};
            empty_q          <= empty;
            capture_done_out <= 1'b0;
            if (!enable_q[1] || start_seen) begin
                done_pend <= 1'b0;
            end else if (flush_done) begin
                done_pend <= 1'b1;
            end else if (done_pend && empty && empty_q) begin
                done_pend        <= 1'b0;
                capture_done_out <= 1'b1;  // empty on two cycles in a row
            end
        end
    end

    always_ff @(posedge rd_clk) begin
        if (reset)
            underflow_sticky <= 1'b0;
        else if (start_seen || clear_errors)
            underflow_sticky <= 1'b0;
        else if (underflow)
            underflow_sticky <= 1'b1;
    end

endmodule

// File: logic/capture_top.sv
`timescale 1ns/1ps

module capture_top #(
    parameter int fifo_depth_log2 = 9,
    parameter int sync_stages     = 2
) (
    input  logic                                  wr_clk,
    input  logic                                  rd_clk,
    input  logic                                  reset,
    input  logic [capture_pkg::axi_addr_w-1:0]    awaddr,
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [capture_pkg::axi_data_w-1:0]    wdata,
    input  logic [capture_pkg::axi_data_w/8-1:0]  wstrb,
    input  logic                                  wvalid,
    output logic                                  wready,
    output logic [1:0]                            bresp,
    output logic                                  bvalid,
    input  logic                                  bready,
    input  logic [capture_pkg::axi_addr_w-1:0]    araddr,
    input  logic                                  arvalid,
    output logic                                  arready,
    output logic [capture_pkg::axi_data_w-1:0]    rdata,
    output logic [1:0]                            rresp,
    output logic                                  rvalid,
    input  logic                                  rready,
    input  logic [capture_pkg::sample_w-1:0]      sample_data,
    input  logic                                  sample_valid,
    input  logic                                  fifo_rd,
    output logic [capture_pkg::word_w-1:0]        fifo_dout,
    output logic                                  fifo_empty,
    output logic                                  capture_start_out,
    output logic                                  capture_done_out
);

    logic                            enable;
    capture_pkg::pack_mode_e         mode;
    logic                            capture_start;
    logic                            capture_stop;
    logic                            clear_errors;
    logic                            capturing;
    logic                            overflow_sticky;
    logic                            underflow_sticky;
    logic                            wr_en;
    logic [capture_pkg::word_w-1:0]  wr_data;
    logic                            full;
    logic                            overflow;
    logic                            empty;
    logic                            underflow;
    logic                            flush_done;
    logic                            start_seen;
    logic                            flush_done_rd;
    logic                            clear_rd;

    // reads as empty while disabled, read clock may be idle
    assign fifo_empty = empty | ~enable;

    capture_regs #(.sync_stages(sync_stages)) regs_i (.*);

    sample_packer packer_i (.*);

    dual_clock_fifo #(
        .fifo_depth_log2 (fifo_depth_log2),
        .sync_stages     (sync_stages)
    ) fifo_i (
        .rd_en   (fifo_rd),
        .rd_data (fifo_dout),
        .*
    );

    pulse_sync #(.sync_stages(sync_stages)) flush_sync_i (
        .src_clk   (wr_clk),
        .dst_clk   (rd_clk),
        .reset     (reset),
        .src_pulse (flush_done),
        .dst_pulse (flush_done_rd)
    );

    pulse_sync #(.sync_stages(sync_stages)) start_sync_i (
        .src_clk   (wr_clk),
        .dst_clk   (rd_clk),
        .reset     (reset),
        .src_pulse (start_seen),
        .dst_pulse (capture_start_out)
    );

    pulse_sync #(.sync_stages(sync_stages)) clear_sync_i (
        .src_clk   (wr_clk),
        .dst_clk   (rd_clk),
        .reset     (reset),
        .src_pulse (clear_errors),
        .dst_pulse (clear_rd)
    );

    drain_monitor monitor_i (
        .rd_clk           (rd_clk),
        .reset            (reset),
        .enable_rd        (enable),
        .flush_done       (flush_done_rd),
        .start_seen       (capture_start_out),
        .clear_errors     (clear_rd),
        .empty            (empty),
        .underflow        (underflow),
        .capture_done_out (capture_done_out),
        .underflow_sticky (underflow_sticky)
    );

endmodule

// File: verification/capture_props.sv
`timescale 1ns/1ps

module capture_props (
    input logic  wr_clk,
    input logic  rd_clk,
    input logic  reset,
    input logic  wr_en,
    input logic  full,
    input logic  overflow,
    input logic  overflow_sticky,
    input logic  bvalid,
    input logic  bready,
    input logic  rvalid,
    input logic  rready,
    input logic  capture_done_out
);

    int fail_count = 0;  // failure tally for the testbench

    // a write into a full fifo is strobed and latched for status
    dropped_write_flagged: assert property (@(posedge wr_clk) disable iff (reset)
        wr_en && full |=> overflow && overflow_sticky)
    else begin
        $error("write strobe while full without overflow");
        fail_count++;
    end

    write_response_held: assert property (@(posedge wr_clk) disable iff (reset)
        bvalid && !bready |=> bvalid)
    else begin
        $error("bvalid dropped before bready");
        fail_count++;
    end

    read_data_held: assert property (@(posedge wr_clk) disable iff (reset)
        rvalid && !rready |=> rvalid)
    else begin
        $error("rvalid dropped before rready");
        fail_count++;
    end

    done_single_cycle: assert property (@(posedge rd_clk) disable iff (reset)
        capture_done_out |=> !capture_done_out)
    else begin
        $error("capture_done_out longer than one cycle");
        fail_count++;
    end

endmodule

bind capture_top capture_props props_i (
    .wr_clk           (wr_clk),
    .rd_clk           (rd_clk),
    .reset            (reset),
    .wr_en            (wr_en),
    .full             (full),
    .overflow         (overflow),
    .overflow_sticky  (overflow_sticky),
    .bvalid           (bvalid),
    .bready           (bready),
    .rvalid           (rvalid),
    .rready           (rready),
    .capture_done_out (capture_done_out)
);

// File: verification/capture_tb.sv
`timescale 1ns/1ps

module capture_tb;

    localparam int depth  = 16;  // 1 << fifo_depth_log2
    localparam int n_rows = 4;

    logic                                  wr_clk;
    logic                                  rd_clk;
    logic                                  reset;
    logic [capture_pkg::axi_addr_w-1:0]    awaddr;
    logic                                  awvalid;
    logic                                  awready;
    logic [capture_pkg::axi_data_w-1:0]    wdata;
    logic [capture_pkg::axi_data_w/8-1:0]  wstrb;
    logic                                  wvalid;
    logic                                  wready;
    logic [1:0]                            bresp;
    logic                                  bvalid;
    logic                                  bready;
    logic [capture_pkg::axi_addr_w-1:0]    araddr;
    logic                                  arvalid;
    logic                                  arready;
    logic [capture_pkg::axi_data_w-1:0]    rdata;
    logic [1:0]                            rresp;
    logic                                  rvalid;
    logic                                  rready;
    logic [capture_pkg::sample_w-1:0]      sample_data;
    logic                                  sample_valid;
    logic                                  fifo_rd;
    logic [capture_pkg::word_w-1:0]        fifo_dout;
    logic                                  fifo_empty;
    logic                                  capture_start_out;
    logic                                  capture_done_out;

    // scenario table, one row per capture
    capture_pkg::pack_mode_e row_mode [n_rows] = '{capture_pkg::mode_sample,
        capture_pkg::mode_sample, capture_pkg::mode_byte, capture_pkg::mode_sample};
    int         row_count  [n_rows] = '{32, 20, 13, 142};
    bit         row_stall  [n_rows] = '{0, 0, 0, 1};      // reader idle until stop
    bit         row_poke   [n_rows] = '{0, 1, 0, 0};      // one read while empty
    int         row_words  [n_rows] = '{9, 6, 2, 40};
    logic [2:0] row_status [n_rows] = '{3'b000, 3'b010, 3'b000, 3'b001};

    logic [31:0] lfsr_state = 32'd92066;
    bit          stream_q [$];  // bit stream, first sample msb first
    logic [63:0] exp_q [$];
    logic [63:0] got_q [$];
    int          start_cnt = 0;
    int          done_cnt  = 0;
    bit          stopped;

    capture_top #(.fifo_depth_log2(4)) dut_i (.*);

    initial begin
        wr_clk = 1'b0;
        forever #10 wr_clk = ~wr_clk;
    end

    initial begin
        rd_clk = 1'b0;
        forever #13 rd_clk = ~rd_clk;
    end

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic expect_equal(string name, logic [63:0] got, logic [63:0] exp);
        assert (got === exp)
        else begin
            $display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_that(bit cond, string what);
        assert (cond)
        else begin
            $display("at %0t ns: %s", $time, what);
            abort_run();
        end
    endtask

    function automatic logic lfsr_step();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb)
            lfsr_state = lfsr_state ^ 32'h8020_0003;  // galois taps
        return lsb;
    endfunction

    function automatic logic [capture_pkg::sample_w-1:0] lfsr_sample();
        logic [capture_pkg::sample_w-1:0] v;
        v = '0;
        for (int i = 0; i < capture_pkg::sample_w; i++)
            v = {v[capture_pkg::sample_w-2:0], lfsr_step()};
        return v;
    endfunction

    // cut the stream into 64-bit words, zeros after the last bit
    function automatic void pack_model();
        logic [63:0] w;
        exp_q.delete();
        while (stream_q.size() > 0) begin
            w = '0;
            for (int i = 0; i < capture_pkg::word_w; i++)
                w = {w[62:0], (stream_q.size() > 0) ? stream_q.pop_front() : 1'b0};
            exp_q.push_back(w);
        end
    endfunction

    task automatic axi_write(logic [3:0] addr, logic [31:0] data);
        @(posedge wr_clk);
        #2;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b0;  // response waits one extra cycle
        do begin
            @(posedge wr_clk);
            #2;
        end while (!(awready && wready));
        @(posedge wr_clk);  // handshake completes here
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        check_that(bvalid, "no write response after the write was accepted");
        expect_equal("bresp", bresp, 2'b00);
        @(posedge wr_clk);
        #2;
        check_that(bvalid, "write response dropped while bready was low");
        bready = 1'b1;
        @(posedge wr_clk);  // response taken, command pulse seen by packer
        #2;
    endtask

    task automatic axi_read(logic [3:0] addr, output logic [31:0] data);
        @(posedge wr_clk);
        #2;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b0;
        do begin
            @(posedge wr_clk);
            #2;
        end while (!arready);
        @(posedge wr_clk);
        #2;
        arvalid = 1'b0;
        check_that(rvalid, "no read data after the address was accepted");
        expect_equal("rresp", rresp, 2'b00);
        data = rdata;
        @(posedge wr_clk);
        #2;
        check_that(rvalid, "read data dropped while rready was low");
        expect_equal("rdata", rdata, data);  // held with rvalid
        rready = 1'b1;
        @(posedge wr_clk);
        #2;
    endtask

    task automatic poll_status(logic [2:0] exp);
        logic [31:0] v;
        int          tries;
        tries = 0;
        do begin
            axi_read(capture_pkg::reg_status, v);
            tries++;
        end while (v != 32'(exp) && tries < 20);  // sticky flags cross clocks
        expect_equal("status", v, exp);
    endtask

    task automatic send_samples(capture_pkg::pack_mode_e mode, int count);
        logic [capture_pkg::sample_w-1:0] s;
        int                               bits;
        bits = (mode == capture_pkg::mode_byte) ? 8 : capture_pkg::sample_w;
        for (int n = 0; n < count; n++) begin
            s = lfsr_sample();
            sample_data  = s;
            sample_valid = 1'b1;
            for (int i = bits - 1; i >= 0; i--)
                stream_q.push_back(s[i]);
            @(posedge wr_clk);
            #2;
        end
        sample_valid = 1'b0;
    endtask

    task automatic collect_words(int n);
        while (got_q.size() < n) begin
            @(posedge rd_clk);
            #2;
            if (!fifo_empty) begin
                fifo_rd = 1'b1;
                @(posedge rd_clk);
                #2;
                fifo_rd = 1'b0;
                got_q.push_back(fifo_dout);  // registered, valid one cycle on
            end
        end
    endtask

    task automatic read_while_empty();
        logic [63:0] last;
        last = fifo_dout;
        @(posedge rd_clk);
        #2;
        check_that(fifo_empty, "fifo_empty was low before the empty read");
        fifo_rd = 1'b1;
        @(posedge rd_clk);
        #2;
        fifo_rd = 1'b0;
        expect_equal("fifo_dout", fifo_dout, last);  // old word kept
    endtask

    always @(negedge rd_clk) begin
        if (capture_start_out)
            start_cnt++;
        if (capture_done_out) begin
            done_cnt++;
            check_that(fifo_empty, "capture_done_out pulsed while fifo_empty was low");
        end
    end

    always @(posedge wr_clk) begin
        if (dut_i.props_i.fail_count != 0) begin
            $display("at %0t ns: a bound assertion failed", $time);
            abort_run();
        end
    end

    initial begin
        int total;
        int limit;
        int cycles;
        total = 0;
        foreach (row_count[i])
            total += row_count[i];
        limit  = 4 * total + 2000;
        cycles = 0;
        forever begin
            @(posedge wr_clk);
            cycles++;
            if (cycles >= limit) begin
                $display("timeout: run still going after %0d wr_clk cycles", limit);
                abort_run();
            end
        end
    end

    initial begin
        logic [31:0] v;
        int          stored;
        reset        = 1'b1;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = 4'hf;
        wvalid       = 1'b0;
        bready       = 1'b1;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b1;
        sample_data  = '0;
        sample_valid = 1'b0;
        fifo_rd      = 1'b0;
        stopped      = 1'b0;
        repeat (3) @(posedge wr_clk);
        #2;
        reset = 1'b0;
        check_that(!bvalid && !rvalid && !awready && !arready,
                   "AXI outputs not idle after reset");
        check_that(!capture_start_out && !capture_done_out, "event pulses high after reset");
        poll_status(3'b000);

        for (int r = 0; r < n_rows; r++) begin
            axi_write(capture_pkg::reg_ctrl, {30'b0, row_mode[r], 1'b1});
            axi_read(capture_pkg::reg_ctrl, v);
            expect_equal("ctrl", v, {30'b0, row_mode[r], 1'b1});
            got_q.delete();
            stopped = 1'b0;
            stored  = row_stall[r] ? depth : row_words[r];
            axi_write(capture_pkg::reg_cmd, 32'h1);
            poll_status(3'b100);  // capturing, both sticky flags cleared by start
            fork
                begin
                    send_samples(row_mode[r], row_count[r]);
                    axi_write(capture_pkg::reg_cmd, 32'h2);
                    stopped = 1'b1;
                end
                begin
                    if (row_stall[r])
                        wait (stopped);
                    collect_words(stored);
                end
            join
            while (done_cnt < r + 1)
                @(posedge wr_clk);  // watchdog bounds this
            pack_model();
            expect_equal("model word count", exp_q.size(), row_words[r]);
            for (int i = 0; i < stored; i++)
                expect_equal("fifo_dout", got_q[i], exp_q[i]);
            if (row_poke[r])
                read_while_empty();
            poll_status(row_status[r]);
            expect_equal("capture_start_out pulses", start_cnt, r + 1);
            expect_equal("capture_done_out pulses", done_cnt, r + 1);
            if (row_status[r][0]) begin
                axi_write(capture_pkg::reg_cmd, 32'h4);
                poll_status(3'b000);
            end
        end

        axi_read(4'hc, v);  // hole in the map
        expect_equal("rdata", v, 32'h0);
        axi_read(capture_pkg::reg_cmd, v);
        expect_equal("rdata", v, 32'h0);

        if (dut_i.props_i.fail_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("%0d bound assertion failures", dut_i.props_i.fail_count);
            abort_run();
        end
    end

endmodule

// File: verilog.f
logic/capture_pkg.sv
logic/pulse_sync.sv
logic/dual_clock_fifo.sv
logic/sample_packer.sv
logic/capture_regs.sv
logic/drain_monitor.sv
logic/capture_top.sv
verification/capture_props.sv
verification/capture_tb.sv

// File: Bender.yml
package:
  name: capture

sources:
  - logic/capture_pkg.sv
  - logic/pulse_sync.sv
  - logic/dual_clock_fifo.sv
  - logic/sample_packer.sv
  - logic/capture_regs.sv
  - logic/drain_monitor.sv
  - logic/capture_top.sv
  - target: simulation
    files:
      - verification/capture_props.sv
      - verification/capture_tb.sv
